//--- design/dnc_erase_pkg.sv
// DNC erase-vector package
// Shared widths, Q8.8 constants and pipeline stage structs for the
// erase-vector logistic pipeline of the DNC write head

package dnc_erase_pkg;

  ////////////////////////////////////////
  // Widths and scalar types
  ////////////////////////////////////////

  // Element word, signed Q8.8
  localparam int word_w  = 16;
  // Vector length and element count
  localparam int index_w = 16;

  typedef logic signed [word_w-1:0] word_t;
  typedef logic [index_w-1:0]       index_t;

  // PLAN segment select, ordered from the top of the curve down
  typedef enum logic [1:0] {
    seg_sat,
    seg_far,
    seg_mid,
    seg_near
  } seg_t;

  // Sequencer FSM
  typedef enum logic {
    st_idle,
    st_run
  } seq_state_t;

  ////////////////////////////////////////
  // Q8.8 constants
  ////////////////////////////////////////

  // Saturated output
  localparam word_t one_q        = 16'sd256;
  // Segment lower bounds on the magnitude
  localparam word_t bound_far_q  = 16'sd1280;
  localparam word_t bound_mid_q  = 16'sd608;
  localparam word_t bound_near_q = 16'sd256;
  // Offsets added after the shift
  localparam word_t off_far_q    = 16'sd216;
  localparam word_t off_mid_q    = 16'sd160;
  localparam word_t off_near_q   = 16'sd128;

  ////////////////////////////////////////
  // Stage structs
  ////////////////////////////////////////

  // Sequencer to segment select, 18 bits
  typedef struct packed {
    logic  valid;
    logic  last;
    word_t value;
  } elem_stage_t;

  // Segment select to evaluate, 21 bits
  typedef struct packed {
    logic  valid;
    logic  last;
    logic  negative;
    word_t magnitude;
    seg_t  seg;
  } seg_stage_t;

endpackage

//--- design/erase_sequencer.sv
// Erase-vector sequencer
// First pipeline stage. Takes a start with the vector length, accepts
// exactly that many element strobes and registers each one, tagging the
// final element as last

module erase_sequencer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  dnc_erase_pkg::index_t      size_in,
  input  logic                       e_in_enable,
  input  dnc_erase_pkg::word_t       e_in,
  output logic                       ready,
  output dnc_erase_pkg::elem_stage_t elem_out
);

  import dnc_erase_pkg::*;

  ////////////////////////////////////////
  // Control state
  ////////////////////////////////////////

  seq_state_t state;
  // Latched vector length
  index_t     size_q;
  // Elements accepted so far in this vector
  index_t     count;

  // Element handshake
  logic accept;
  logic accept_last;

  // Stage output registers
  logic  valid_q;
  logic  last_q;
  word_t value_q;

  // Strobes only count while a vector is running
  assign accept      = (state == st_run) && e_in_enable;
  // Element W closes the vector
  assign accept_last = accept && (count == size_q - index_t'(1));

  // Free for a new vector as soon as the FSM sits in idle
  assign ready = (state == st_idle);

  ////////////////////////////////////////
  // FSM and element counter
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= st_idle;
      size_q <= '0;
      count  <= '0;
    end else begin
      case (state)
        st_idle: begin
          // Zero length start is dropped
          if (start && (size_in != '0)) begin
            state  <= st_run;
            size_q <= size_in;
            count  <= '0;
          end
        end
        default: begin
          if (accept_last) begin
            state <= st_idle;
          end else if (accept) begin
            count <= count + index_t'(1);
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= accept;
      last_q  <= accept_last;
    end
  end

  // Data word, only meaningful alongside valid
  always_ff @(posedge clk) begin
    if (accept) begin
      value_q <= e_in;
    end
  end

  assign elem_out = '{valid: valid_q, last: last_q, value: value_q};

endmodule

//--- design/logistic_segment.sv
// Logistic segment select
// Second pipeline stage. Splits each element into sign and magnitude and
// picks the PLAN segment the magnitude falls in

module logistic_segment (
  input  logic                       clk,
  input  logic                       rst,
  input  dnc_erase_pkg::elem_stage_t elem_in,
  output dnc_erase_pkg::seg_stage_t  seg_out
);

  import dnc_erase_pkg::*;

  // Combinational split of the incoming word
  logic  negative;
  word_t magnitude;
  seg_t  seg;

  // Stage registers
  logic  valid_q;
  logic  last_q;
  logic  negative_q;
  word_t magnitude_q;
  seg_t  seg_q;

  ////////////////////////////////////////
  // Sign, magnitude, segment
  ////////////////////////////////////////

  always_comb begin
    negative  = elem_in.value[word_w-1];
    // Two's complement absolute value
    // The most negative code wraps to itself, 32768 when read unsigned
    magnitude = negative ? -elem_in.value : elem_in.value;

    // Unsigned compares so the wrapped code lands in saturation
    if ($unsigned(magnitude) >= $unsigned(bound_far_q)) begin
      seg = seg_sat;
    end else if ($unsigned(magnitude) >= $unsigned(bound_mid_q)) begin
      seg = seg_far;
    end else if ($unsigned(magnitude) >= $unsigned(bound_near_q)) begin
      seg = seg_mid;
    end else begin
      seg = seg_near;
    end
  end

  ////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= elem_in.valid;
      last_q  <= elem_in.last;
    end
  end

  // Payload follows the strobe
  always_ff @(posedge clk) begin
    if (elem_in.valid) begin
      negative_q  <= negative;
      magnitude_q <= magnitude;
      seg_q       <= seg;
    end
  end

  assign seg_out = '{
    valid:     valid_q,
    last:      last_q,
    negative:  negative_q,
    magnitude: magnitude_q,
    seg:       seg_q
  };

endmodule

//--- design/logistic_evaluate.sv
// Logistic segment evaluate
// Third pipeline stage. Evaluates the selected PLAN line with a truncating
// shift and an offset add, mirrors it for negative inputs and drives the
// output strobes

module logistic_evaluate (
  input  logic                      clk,
  input  logic                      rst,
  input  dnc_erase_pkg::seg_stage_t seg_in,
  output logic                      e_out_enable,
  output dnc_erase_pkg::word_t      e_out,
  output logic                      e_out_last
);

  import dnc_erase_pkg::*;

  // Shift amounts per segment
  localparam int shift_far  = 5;
  localparam int shift_mid  = 3;
  localparam int shift_near = 2;

  // Sigmoid of the magnitude
  word_t pos_value;
  // Final value after the sign mirror
  word_t result;

  ////////////////////////////////////////
  // Segment arithmetic
  ////////////////////////////////////////

  always_comb begin
    // Magnitude is non-negative below saturation, so the shift truncates
    case (seg_in.seg)
      seg_far: begin
        // x/32 + 0.84375
        pos_value = (seg_in.magnitude >>> shift_far) + off_far_q;
      end
      seg_mid: begin
        // x/8 + 0.625
        pos_value = (seg_in.magnitude >>> shift_mid) + off_mid_q;
      end
      seg_near: begin
        // x/4 + 0.5
        pos_value = (seg_in.magnitude >>> shift_near) + off_near_q;
      end
      default: begin
        // Saturated, magnitude not looked at
        pos_value = one_q;
      end
    endcase

    // sigmoid(-x) = 1 - sigmoid(x)
    if (seg_in.negative) begin
      result = one_q - pos_value;
    end else begin
      result = pos_value;
    end
  end

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      e_out_enable <= 1'b0;
      e_out_last   <= 1'b0;
    end else begin
      e_out_enable <= seg_in.valid;
      e_out_last   <= seg_in.last;
    end
  end

  // Result word held between strobes
  always_ff @(posedge clk) begin
    if (seg_in.valid) begin
      e_out <= result;
    end
  end

endmodule

//--- design/dnc_erase_vector.sv
// DNC erase vector
// Write-head erase vector, e(t;k) = sigmoid(e^(t;k)) for k in 0 to W-1.
// Three stage pipeline: sequencer, segment select, segment evaluate.
// Fixed latency of three clocks from e_in_enable to e_out_enable

module dnc_erase_vector (
  input  logic                  clk,
  input  logic                  rst,
  // Vector control
  input  logic                  start,
  input  dnc_erase_pkg::index_t size_in,
  output logic                  ready,
  // Element stream in
  input  logic                  e_in_enable,
  input  dnc_erase_pkg::word_t  e_in,
  // Element stream out
  output logic                  e_out_enable,
  output dnc_erase_pkg::word_t  e_out,
  output logic                  e_out_last
);

  import dnc_erase_pkg::*;

  // Stage links
  elem_stage_t elem_s;
  seg_stage_t  seg_s;

  // Start handshake and element counting
  erase_sequencer sequencer (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .size_in     (size_in),
    .e_in_enable (e_in_enable),
    .e_in        (e_in),
    .ready       (ready),
    .elem_out    (elem_s)
  );

  // Sign, magnitude and segment
  logistic_segment segment (
    .clk     (clk),
    .rst     (rst),
    .elem_in (elem_s),
    .seg_out (seg_s)
  );

  // PLAN line and negative mirror
  logistic_evaluate evaluate (
    .clk          (clk),
    .rst          (rst),
    .seg_in       (seg_s),
    .e_out_enable (e_out_enable),
    .e_out        (e_out),
    .e_out_last   (e_out_last)
  );

endmodule

//--- dv/dnc_erase_vector_asserts.sv
// Erase-vector handshake checks
// Bound to the top level and watches the element strobes at its ports

module dnc_erase_vector_asserts (
  input logic clk,
  input logic rst,
  input logic ready,
  input logic e_in_enable,
  input logic e_out_enable,
  input logic e_out_last
);

  timeunit 1ns;
  timeprecision 100ps;

  // Element taken by the sequencer, only while a vector runs
  logic accepted;

  assign accepted = e_in_enable && !ready;

  ////////////////////////////////////////
  // Pipeline properties
  ////////////////////////////////////////

  // Pipeline is empty for three cycles after reset
  quiet_after_reset: assert property (
    @(posedge clk) e_out_enable |-> !$past(rst, 1) && !$past(rst, 2) && !$past(rst, 3)
  ) else $error("output strobe within three cycles of reset");

  // Every accepted element comes out three cycles later
  accept_to_output: assert property (
    @(posedge clk) disable iff (rst) $past(accepted, 3) |-> e_out_enable
  ) else $error("accepted element did not come out after three cycles");

  // And nothing comes out without one
  output_from_accept: assert property (
    @(posedge clk) disable iff (rst) e_out_enable |-> $past(accepted, 3)
  ) else $error("output strobe without an element accepted three cycles before");

  // Last tag only rides on a strobe
  last_with_enable: assert property (
    @(posedge clk) disable iff (rst) e_out_last |-> e_out_enable
  ) else $error("e_out_last high without e_out_enable");

endmodule

bind dnc_erase_vector dnc_erase_vector_asserts handshake_checks (
  .clk          (clk),
  .rst          (rst),
  .ready        (ready),
  .e_in_enable  (e_in_enable),
  .e_out_enable (e_out_enable),
  .e_out_last   (e_out_last)
);

//--- dv/dnc_erase_vector_tb.sv
// Erase-vector testbench
// Reads vector commands from the test file, drives the strobes on the
// falling edge, checks values, last tags, latency and ready timing

module dnc_erase_vector_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import dnc_erase_pkg::*;

  // Clocks from accept edge to sampled output
  localparam int latency      = 3;
  localparam int reset_cycles = 16;

  // DUT ports
  logic   clk;
  logic   rst;
  logic   start;
  index_t size_in;
  logic   e_in_enable;
  word_t  e_in;
  logic   ready;
  logic   e_out_enable;
  word_t  e_out;
  logic   e_out_last;

  // Parsed commands, kind plus two arguments
  byte cmd_kind[$];
  int  cmd_a[$];
  int  cmd_b[$];

  // Pending outputs in stream order
  int exp_word[$];
  int exp_last[$];
  int exp_cycle[$];
  int exp_test[$];

  // Per test bookkeeping
  string test_desc[$];
  int    test_errs[$];
  int    cur_test = -1;

  int errors      = 0;
  int checks      = 0;
  int cycles      = 0;
  int cycle_limit = 1000000;

  logic [31:0] lfsr_state = 32'h5627d18a;

  dnc_erase_vector uut (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .size_in      (size_in),
    .ready        (ready),
    .e_in_enable  (e_in_enable),
    .e_in         (e_in),
    .e_out_enable (e_out_enable),
    .e_out        (e_out),
    .e_out_last   (e_out_last)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference model and random source
  ////////////////////////////////////////

  // PLAN sigmoid on a signed Q8.8 code
  function automatic int sigmoid_ref(input int x);
    int mag;
    int pos;
    mag = (x < 0) ? -x : x;
    if (mag >= 1280) begin
      pos = 256;
    end else if (mag >= 608) begin
      pos = (mag >> 5) + 216;
    end else if (mag >= 256) begin
      pos = (mag >> 3) + 160;
    end else begin
      pos = (mag >> 2) + 128;
    end
    return (x < 0) ? 256 - pos : pos;
  endfunction

  // 16 bit code read as signed
  function automatic int to_signed16(input int v);
    int w;
    w = v & 32'hffff;
    return (w >= 32768) ? w - 65536 : w;
  endfunction

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic int lfsr_draw(input int nbits);
    int val;
    val = 0;
    for (int i = 0; i < nbits; i++) begin
      val = (val << 1) | int'(lfsr_bit());
    end
    return val;
  endfunction

  ////////////////////////////////////////
  // Checking and reporting
  ////////////////////////////////////////

  task automatic check_value(input string what, input int got, input int expected,
                             input int test_id);
    checks++;
    if (got !== expected) begin
      $display("ERROR at %0t: test %0d %s, got %0d expected %0d",
               $time, test_id, what, got, expected);
      errors++;
      if (test_id >= 0) begin
        test_errs[test_id]++;
      end
    end
  endtask

  function automatic int new_test(input string desc);
    test_desc.push_back(desc);
    test_errs.push_back(0);
    cur_test = test_desc.size() - 1;
    return cur_test;
  endfunction

  task automatic report_test(input int id);
    $display("Test %0d, %s: %0d errors", id, test_desc[id], test_errs[id]);
  endtask

  // Outputs sampled mid cycle
  always @(negedge clk) begin : output_monitor
    int test_id;
    int want_word;
    int want_last;
    int want_cycle;
    if (!rst && e_out_enable) begin
      if (exp_word.size() == 0) begin
        $display("Unexpected output strobe at %0t, value %0d with nothing pending",
                 $time, e_out);
        errors++;
        if (cur_test >= 0) begin
          test_errs[cur_test]++;
        end
      end else begin
        test_id    = exp_test.pop_front();
        want_word  = exp_word.pop_front();
        want_last  = exp_last.pop_front();
        want_cycle = exp_cycle.pop_front();
        check_value("output value", int'(e_out), want_word, test_id);
        check_value("last tag", int'(e_out_last), want_last, test_id);
        check_value("output cycle", cycles, want_cycle, test_id);
        if (want_last != 0) begin
          report_test(test_id);
        end
      end
    end
  end

  // Cycle count and run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, %0d outputs never arrived",
               cycle_limit, exp_word.size());
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Test file and stimulus
  ////////////////////////////////////////

  task automatic load_tests();
    int    fd;
    int    n;
    int    a;
    int    b;
    byte   kind;
    string line;
    fd = $fopen("dv/dnc_erase_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file dv/dnc_erase_tests.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n <= 0 || line.len() < 1) begin
        continue;
      end
      kind = line.getc(0);
      a = 0;
      b = 0;
      if (kind == "V" || kind == "R") begin
        n = $sscanf(line.substr(1, line.len() - 1), "%d %d", a, b);
      end else if (kind == "E" || kind == "S") begin
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
      end else if (kind != "Z") begin
        continue;
      end
      cmd_kind.push_back(kind);
      cmd_a.push_back(a);
      cmd_b.push_back(b);
    end
    $fclose(fd);
  endtask

  // Budget from element count plus gaps and drain
  function automatic int compute_limit();
    int total;
    int gap;
    total = reset_cycles + 8 * latency + 20;
    gap = 0;
    for (int i = 0; i < cmd_kind.size(); i++) begin
      case (cmd_kind[i])
        "V": begin
          gap = cmd_b[i];
          total += 2 + latency;
        end
        "E": total += gap + 1;
        "R": total += 2 + latency + 4 * cmd_a[i];
        default: total += latency + 3;
      endcase
    end
    return total;
  endfunction

  task automatic start_vector(input int size, input int test_id);
    start   = 1'b1;
    size_in = 16'(size);
    @(negedge clk);
    start = 1'b0;
    check_value("ready after start", int'(ready), (size == 0) ? 1 : 0, test_id);
  endtask

  // One strobe, ready rises only after the last element
  task automatic send_element(input int word, input int expected, input int is_last,
                              input int test_id);
    e_in_enable = 1'b1;
    e_in        = 16'(word);
    exp_word.push_back(expected);
    exp_last.push_back(is_last);
    exp_cycle.push_back(cycles + latency);
    exp_test.push_back(test_id);
    @(negedge clk);
    e_in_enable = 1'b0;
    check_value("ready after element", int'(ready), is_last, test_id);
  endtask

  // Strobe while idle, must be dropped
  task automatic run_stray(input int word);
    int id;
    id = new_test("stray strobe while idle");
    e_in_enable = 1'b1;
    e_in        = 16'(word);
    @(negedge clk);
    e_in_enable = 1'b0;
    repeat (latency + 1) @(negedge clk);
    report_test(id);
  endtask

  task automatic run_zero_size();
    int id;
    id = new_test("zero-size start");
    start_vector(0, id);
    e_in_enable = 1'b1;
    e_in        = 16'h0100;
    @(negedge clk);
    e_in_enable = 1'b0;
    repeat (latency + 1) @(negedge clk);
    check_value("ready after zero-size start", int'(ready), 1, id);
    report_test(id);
  endtask

  // Consumes the E lines of one V command
  task automatic run_file_vector(inout int idx);
    int id;
    int size;
    int gap;
    size = cmd_a[idx];
    gap  = cmd_b[idx];
    id = new_test($sformatf("file vector of %0d, gap %0d", size, gap));
    start_vector(size, id);
    for (int k = 0; k < size; k++) begin
      idx++;
      if (idx >= cmd_kind.size() || cmd_kind[idx] != "E") begin
        $display("Test file is malformed, vector %0d has fewer than %0d elements", id, size);
        errors++;
        test_errs[id]++;
        return;
      end
      send_element(to_signed16(cmd_a[idx]), cmd_b[idx], (k == size - 1) ? 1 : 0, id);
      if (k != size - 1) begin
        repeat (gap) @(negedge clk);
      end
    end
  endtask

  task automatic run_random_vector(input int size);
    int id;
    int word;
    int gap;
    id = new_test($sformatf("random vector of %0d", size));
    start_vector(size, id);
    for (int k = 0; k < size; k++) begin
      // Roughly -16.0 to 16.0, reaches every segment
      word = lfsr_draw(13) - 4096;
      send_element(word, sigmoid_ref(word), (k == size - 1) ? 1 : 0, id);
      if (k != size - 1) begin
        gap = lfsr_draw(2);
        repeat (gap) @(negedge clk);
      end
    end
  endtask

  initial begin : stimulus
    int idx;
    rst         = 1'b1;
    start       = 1'b0;
    size_in     = '0;
    e_in_enable = 1'b0;
    e_in        = '0;
    load_tests();
    cycle_limit = compute_limit();
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;
    check_value("ready after reset", int'(ready), 1, -1);

    idx = 0;
    while (idx < cmd_kind.size()) begin
      case (cmd_kind[idx])
        "S": run_stray(cmd_a[idx]);
        "Z": run_zero_size();
        "V": run_file_vector(idx);
        "R": run_random_vector(cmd_a[idx]);
        default: begin
          $display("Test file has an element line outside any vector");
          errors++;
        end
      endcase
      idx++;
    end

    // Drain, then watch for stray outputs
    while (exp_word.size() != 0) begin
      @(negedge clk);
    end
    repeat (latency + 2) @(negedge clk);

    $display("Tests %0d, checks %0d, errors %0d", test_desc.size(), checks, errors);
    if (errors == 0 && test_desc.size() > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- dv/dnc_erase_tests.txt
# V <size> <gap> starts a vector (decimal), E <input> <expected> is one element (hex Q8.8)
# S <input> is a strobe while idle, Z is a zero-size start, R <size> is an LFSR vector
S 0123
Z
V 11 1
E 0000 0080
E 0001 0080
E 0003 0080
E 0004 0081
E 00FF 00BF
E 0100 00C0
E 025F 00EB
E 0260 00EB
E 04FF 00FF
E 0500 0100
E 7FFF 0100
S 0456
V 7 0
E FFFF 0080
E FFFC 007F
E FF00 0040
E FDA0 0015
E FB00 0000
E 8000 0000
E FE80 0030
V 3 0
E 0180 00D0
E 0300 00F0
E FD00 0010
S 7FFF
R 12
V 2 2
E 0080 00A0
E FF80 0060

//--- dnc_erase.f
design/dnc_erase_pkg.sv
design/erase_sequencer.sv
design/logistic_segment.sv
design/logistic_evaluate.sv
design/dnc_erase_vector.sv
dv/dnc_erase_vector_asserts.sv
dv/dnc_erase_vector_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the erase-vector testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f dnc_erase.f \
  --top-module dnc_erase_vector_tb -o sim \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim > sim.log 2>&1
run_status=$?
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "Simulation reported failure"; exit 1; }
[ "$run_status" -eq 0 ] && grep -q "=== PASS ===" sim.log \
  || { echo "Simulation did not complete cleanly"; exit 1; }
echo "Simulation passed"
